//--- lx_slice.f
src/lx_pkg.sv
src/lx_alu.sv
src/lx_decode.sv
src/lx_execute.sv
src/lx_result.sv
src/lx_slice.sv
testbench/tb_lx_slice.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_lx_slice -f lx_slice.f -o sim_lx_slice \
    && ./obj_dir/sim_lx_slice > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qs "TESTS FAILED" sim.log && exit 1
grep -qs "TESTS PASSED" sim.log && exit 0 || exit 1

//--- src/lx_alu.sv
`timescale 1ns/1ps

module lx_alu (
    input  logic            clk,
    input  logic            arst_n,
    input  lx_pkg::alu_op_t alu_op,
    input  logic            alu_start,
    input  logic [31:0]     src1,
    input  logic [31:0]     src2,
    output logic [31:0]     result,
    output logic            alu_wait
);
    import lx_pkg::*;

    logic        busy;
    logic [4:0]  step_cnt;
    logic [31:0] rem_q;
    logic [31:0] quo_q;
    logic [31:0] dvs_q;
    logic        neg_q;
    logic        is_signed;
    logic [31:0] src1_mag;
    logic [31:0] src2_mag;
    logic [32:0] shifted;
    logic [33:0] trial;
    logic [31:0] div_result;

    assign is_signed = alu_op == alu_div;
    assign src1_mag  = (is_signed && src1[31]) ? -src1 : src1;
    assign src2_mag  = (is_signed && src2[31]) ? -src2 : src2;

    assign shifted = {rem_q, quo_q[31]};
    assign trial   = {1'b0, shifted} - {2'b00, dvs_q}; // bit 33 set means the divisor did not fit.

    assign alu_wait = alu_start | busy; // the start cycle already stalls execute.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            step_cnt <= '0;
        end else if (alu_start) begin
            busy     <= 1'b1;
            step_cnt <= '0;
        end else if (busy) begin
            step_cnt <= step_cnt + 5'd1;
            if (step_cnt == 5'd31) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alu_start) begin
            rem_q <= '0;
            quo_q <= src1_mag; // the dividend shifts out as the quotient shifts in.
            dvs_q <= src2_mag;
            neg_q <= is_signed && (src1[31] ^ src2[31]) && (src2 != '0);
        end else if (busy) begin
            if (!trial[33]) begin
                rem_q <= trial[31:0];
                quo_q <= {quo_q[30:0], 1'b1};
            end else begin
                rem_q <= shifted[31:0];
                quo_q <= {quo_q[30:0], 1'b0};
            end
        end
    end

    // a zero divisor never fails the trial, so every quotient bit ends up set.
    assign div_result = neg_q ? -quo_q : quo_q;

    always_comb begin
        case (alu_op)
            alu_add:  result = src1 + src2;
            alu_sub:  result = src1 - src2;
            alu_and:  result = src1 & src2;
            alu_or:   result = src1 | src2;
            alu_xor:  result = src1 ^ src2;
            alu_slt:  result = {31'd0, $signed(src1) < $signed(src2)};
            alu_sltu: result = {31'd0, src1 < src2};
            default:  result = div_result;
        endcase
    end

    // execute must not present a second divide before the first has drained.
    a_no_restart: assert property (@(posedge clk) disable iff (!arst_n)
        alu_start |-> !busy);

endmodule

//--- src/lx_decode.sv
`timescale 1ns/1ps

module lx_decode (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             in_valid,
    input  lx_pkg::dec_in_t  in_data,
    output logic             in_allow,
    output logic             id_valid,
    output lx_pkg::id_ex_t   id_data,
    input  logic             ex_allow
);
    import lx_pkg::*;

    logic    dec_valid;
    dec_in_t din_r;
    logic    hit_3r;

    assign in_allow = ~dec_valid | ex_allow; // decode always finishes in one cycle.
    assign id_valid = dec_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else if (in_allow) begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allow) begin
            din_r <= in_data;
        end
    end

    always_comb begin
        id_data             = '0;
        id_data.pc          = din_r.pc;
        id_data.rj_value    = din_r.rj_value;
        id_data.rkd_value   = din_r.rkd_value;
        id_data.imm         = {{20{din_r.instr.fmt_2ri12.si12[11]}}, din_r.instr.fmt_2ri12.si12};
        id_data.alu_op      = alu_add; // loads and stores add the offset to rj.
        id_data.mem_size    = size_w;
        id_data.dest        = din_r.instr.fmt_3r.rd;
        id_data.gr_we       = 1'b0;
        id_data.exc         = exc_ine; // cleared below once a known opcode matches.
        hit_3r              = 1'b1;
        case (din_r.instr.fmt_3r.opcode)
            op_add_w:  id_data.alu_op = alu_add;
            op_sub_w:  id_data.alu_op = alu_sub;
            op_and:    id_data.alu_op = alu_and;
            op_or:     id_data.alu_op = alu_or;
            op_xor:    id_data.alu_op = alu_xor;
            op_slt:    id_data.alu_op = alu_slt;
            op_sltu:   id_data.alu_op = alu_sltu;
            op_div_w:  id_data.alu_op = alu_div;
            op_div_wu: id_data.alu_op = alu_divu;
            default:   hit_3r = 1'b0;
        endcase
        if (hit_3r) begin
            id_data.gr_we = 1'b1;
            id_data.exc   = exc_none;
        end else begin
            id_data.src2_is_imm = 1'b1;
            id_data.gr_we       = 1'b1;
            id_data.exc         = exc_none;
            case (din_r.instr.fmt_2ri12.opcode)
                op_addi_w: id_data.mem_read = 1'b0;
                op_ld_b:   {id_data.mem_read, id_data.mem_size, id_data.mem_signed} = {1'b1, size_b, 1'b1};
                op_ld_h:   {id_data.mem_read, id_data.mem_size, id_data.mem_signed} = {1'b1, size_h, 1'b1};
                op_ld_w:   {id_data.mem_read, id_data.mem_size, id_data.mem_signed} = {1'b1, size_w, 1'b1};
                op_ld_bu:  {id_data.mem_read, id_data.mem_size} = {1'b1, size_b};
                op_ld_hu:  {id_data.mem_read, id_data.mem_size} = {1'b1, size_h};
                op_st_b:   {id_data.mem_write, id_data.mem_size, id_data.gr_we} = {1'b1, size_b, 1'b0};
                op_st_h:   {id_data.mem_write, id_data.mem_size, id_data.gr_we} = {1'b1, size_h, 1'b0};
                op_st_w:   {id_data.mem_write, id_data.mem_size, id_data.gr_we} = {1'b1, size_w, 1'b0};
                default: begin
                    id_data.src2_is_imm = 1'b0;
                    id_data.gr_we       = 1'b0;
                    id_data.exc         = exc_ine;
                end
            endcase
        end
    end

endmodule

//--- src/lx_execute.sv
`timescale 1ns/1ps

module lx_execute (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            id_valid,
    input  lx_pkg::id_ex_t  id_data,
    output logic            ex_allow,
    output logic            ex_valid,
    output lx_pkg::ex_rs_t  ex_data,
    input  logic            rs_allow,
    output logic            sram_en,
    output logic [3:0]      sram_we,
    output logic [31:0]     sram_addr,
    output logic [31:0]     sram_wdata
);
    import lx_pkg::*;

    logic        ex_valid_r;
    id_ex_t      ex_r;
    logic        div_issued;
    logic        alu_start;
    logic        alu_wait;
    logic        ready_go;
    logic [31:0] alu_src2;
    logic [31:0] alu_result;
    logic [1:0]  addr_low2;
    logic        misaligned;
    exc_t        exc_out;
    logic [3:0]  lanes;

    assign ready_go = ~alu_wait;
    assign ex_allow = ~ex_valid_r | (ready_go & rs_allow);
    assign ex_valid = ex_valid_r & ready_go;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid_r <= 1'b0;
            div_issued <= 1'b0;
        end else begin
            if (ex_allow) begin
                ex_valid_r <= id_valid;
            end
            if (ex_allow) begin
                div_issued <= 1'b0;
            end else if (alu_start) begin
                div_issued <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid && ex_allow) begin
            ex_r <= id_data;
        end
    end

    // only the first cycle of a divide starts the divider.
    assign alu_start = ex_valid_r && !div_issued
                    && (ex_r.alu_op == alu_div || ex_r.alu_op == alu_divu);
    assign alu_src2  = ex_r.src2_is_imm ? ex_r.imm : ex_r.rkd_value;

    lx_alu u_alu (
        .clk       (clk),
        .arst_n    (arst_n),
        .alu_op    (ex_r.alu_op),
        .alu_start (alu_start),
        .src1      (ex_r.rj_value),
        .src2      (alu_src2),
        .result    (alu_result),
        .alu_wait  (alu_wait)
    );

    assign addr_low2  = alu_result[1:0];
    assign misaligned = (ex_r.mem_read || ex_r.mem_write)
                     && ((ex_r.mem_size == size_h && addr_low2[0])
                      || (ex_r.mem_size == size_w && addr_low2 != 2'b00));
    assign exc_out    = (ex_r.exc != exc_none) ? ex_r.exc
                      : (misaligned ? exc_adem : exc_none);

    always_comb begin
        case (ex_r.mem_size)
            size_b: begin
                lanes      = 4'b0001 << addr_low2;
                sram_wdata = {4{ex_r.rkd_value[7:0]}};
            end
            size_h: begin
                lanes      = addr_low2[1] ? 4'b1100 : 4'b0011;
                sram_wdata = {2{ex_r.rkd_value[15:0]}};
            end
            default: begin
                lanes      = 4'b1111;
                sram_wdata = ex_r.rkd_value;
            end
        endcase
    end

    assign sram_en   = ex_valid_r && (ex_r.mem_read || ex_r.mem_write) && exc_out == exc_none;
    assign sram_we   = (sram_en && ex_r.mem_write) ? lanes : 4'b0000;
    assign sram_addr = {alu_result[31:2], 2'b00};

    always_comb begin
        ex_data            = '0;
        ex_data.pc         = ex_r.pc;
        ex_data.alu_result = alu_result;
        ex_data.mem_read   = ex_r.mem_read;
        ex_data.mem_size   = ex_r.mem_size;
        ex_data.mem_signed = ex_r.mem_signed;
        ex_data.addr_low2  = addr_low2;
        ex_data.dest       = ex_r.dest;
        ex_data.gr_we      = ex_r.gr_we;
        ex_data.exc        = exc_out;
    end

    // a request only leaves for an access that is aligned to its size.
    a_no_sram_on_adem: assert property (@(posedge clk) disable iff (!arst_n)
        sram_en |-> ex_r.mem_size == size_b
                 || (ex_r.mem_size == size_h && !alu_result[0])
                 || alu_result[1:0] == 2'b00);

endmodule

//--- src/lx_pkg.sv
package lx_pkg;

    localparam int xlen = 32;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_div,
        alu_divu
    } alu_op_t;

    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] si12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri12_t;

    typedef union packed {
        fmt_3r_t    fmt_3r;
        fmt_2ri12_t fmt_2ri12;
    } instr_u;

    // 3R opcodes sit in bits 31:15 of the word.
    localparam logic [16:0] op_add_w  = 17'h00020;
    localparam logic [16:0] op_sub_w  = 17'h00022;
    localparam logic [16:0] op_slt    = 17'h00024;
    localparam logic [16:0] op_sltu   = 17'h00025;
    localparam logic [16:0] op_and    = 17'h00029;
    localparam logic [16:0] op_or     = 17'h0002a;
    localparam logic [16:0] op_xor    = 17'h0002b;
    localparam logic [16:0] op_div_w  = 17'h00040;
    localparam logic [16:0] op_div_wu = 17'h00042;

    // 2RI12 opcodes sit in bits 31:22 of the word.
    localparam logic [9:0] op_addi_w = 10'h00a;
    localparam logic [9:0] op_ld_b   = 10'h0a0;
    localparam logic [9:0] op_ld_h   = 10'h0a1;
    localparam logic [9:0] op_ld_w   = 10'h0a2;
    localparam logic [9:0] op_st_b   = 10'h0a4;
    localparam logic [9:0] op_st_h   = 10'h0a5;
    localparam logic [9:0] op_st_w   = 10'h0a6;
    localparam logic [9:0] op_ld_bu  = 10'h0a8;
    localparam logic [9:0] op_ld_hu  = 10'h0a9;

    typedef enum logic [1:0] {
        size_b = 2'd0,
        size_h = 2'd1,
        size_w = 2'd2
    } mem_size_t;

    typedef enum logic [1:0] {
        exc_none = 2'd0,
        exc_ine  = 2'd1,
        exc_adem = 2'd2
    } exc_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        instr_u          instr;
        logic [xlen-1:0] rj_value;
        logic [xlen-1:0] rkd_value;
    } dec_in_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rj_value;
        logic [xlen-1:0] rkd_value;
        logic [xlen-1:0] imm;
        alu_op_t         alu_op;
        logic            src2_is_imm;
        logic            mem_read;
        logic            mem_write;
        mem_size_t       mem_size;
        logic            mem_signed;
        logic [4:0]      dest;
        logic            gr_we;
        exc_t            exc;
    } id_ex_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] alu_result;
        logic            mem_read;
        mem_size_t       mem_size;
        logic            mem_signed;
        logic [1:0]      addr_low2;
        logic [4:0]      dest;
        logic            gr_we;
        exc_t            exc;
    } ex_rs_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [4:0]      dest;
        logic            we;
        logic [xlen-1:0] data;
        exc_t            exc;
    } wb_t;

endpackage

//--- src/lx_result.sv
`timescale 1ns/1ps

module lx_result (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            ex_valid,
    input  lx_pkg::ex_rs_t  ex_data,
    output logic            rs_allow,
    input  logic [31:0]     sram_rdata,
    output logic            wb_valid,
    output lx_pkg::wb_t     wb_data,
    input  logic            wb_allow
);
    import lx_pkg::*;

    logic        rs_valid;
    ex_rs_t      rs_r;
    logic        data_ready;
    logic [31:0] rdata_r;
    logic        need_data;
    logic        ready_go;
    logic [31:0] byte_word;
    logic [15:0] half_sel;
    logic [31:0] load_data;

    assign need_data = rs_r.mem_read && rs_r.exc == exc_none; // faulted loads never read memory.
    assign ready_go  = ~need_data | data_ready;
    assign rs_allow  = ~rs_valid | (ready_go & wb_allow);
    assign wb_valid  = rs_valid & ready_go;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rs_valid   <= 1'b0;
            data_ready <= 1'b0;
        end else begin
            if (rs_allow) begin
                rs_valid <= ex_valid;
            end
            if (rs_allow) begin
                data_ready <= 1'b0;
            end else if (rs_valid && need_data) begin
                data_ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid && rs_allow) begin
            rs_r <= ex_data;
        end
        if (rs_valid && need_data && !data_ready) begin
            rdata_r <= sram_rdata; // the SRAM answers only in the first result cycle.
        end
    end

    assign byte_word = rdata_r >> {rs_r.addr_low2, 3'b000};
    assign half_sel  = rs_r.addr_low2[1] ? rdata_r[31:16] : rdata_r[15:0];

    always_comb begin
        case (rs_r.mem_size)
            size_b:  load_data = {{24{rs_r.mem_signed & byte_word[7]}}, byte_word[7:0]};
            size_h:  load_data = {{16{rs_r.mem_signed & half_sel[15]}}, half_sel};
            default: load_data = rdata_r;
        endcase
    end

    always_comb begin
        wb_data      = '0;
        wb_data.pc   = rs_r.pc;
        wb_data.dest = rs_r.dest;
        wb_data.we   = rs_r.gr_we && rs_r.exc == exc_none;
        wb_data.data = need_data ? load_data : rs_r.alu_result;
        wb_data.exc  = rs_r.exc;
    end

    a_wb_hold: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid && !wb_allow |=> wb_valid && $stable(wb_data));

endmodule

//--- src/lx_slice.sv
`timescale 1ns/1ps

module lx_slice (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             in_valid,
    input  lx_pkg::dec_in_t  in_data,
    output logic             in_allow,
    output logic             sram_en,
    output logic [3:0]       sram_we,
    output logic [31:0]      sram_addr,
    output logic [31:0]      sram_wdata,
    input  logic [31:0]      sram_rdata,
    output logic             wb_valid,
    output lx_pkg::wb_t      wb_data,
    input  logic             wb_allow
);
    import lx_pkg::*;

    logic   id_valid;
    id_ex_t id_data;
    logic   ex_allow;
    logic   ex_valid;
    ex_rs_t ex_data;
    logic   rs_allow;

    lx_decode u_decode (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_data  (in_data),
        .in_allow (in_allow),
        .id_valid (id_valid),
        .id_data  (id_data),
        .ex_allow (ex_allow)
    );

    lx_execute u_execute (
        .clk        (clk),
        .arst_n     (arst_n),
        .id_valid   (id_valid),
        .id_data    (id_data),
        .ex_allow   (ex_allow),
        .ex_valid   (ex_valid),
        .ex_data    (ex_data),
        .rs_allow   (rs_allow),
        .sram_en    (sram_en),
        .sram_we    (sram_we),
        .sram_addr  (sram_addr),
        .sram_wdata (sram_wdata)
    );

    lx_result u_result (
        .clk        (clk),
        .arst_n     (arst_n),
        .ex_valid   (ex_valid),
        .ex_data    (ex_data),
        .rs_allow   (rs_allow),
        .sram_rdata (sram_rdata),
        .wb_valid   (wb_valid),
        .wb_data    (wb_data),
        .wb_allow   (wb_allow)
    );

endmodule

//--- testbench/tb_lx_slice.sv
`timescale 1ns/1ps

module tb_lx_slice;
    import lx_pkg::*;

    localparam int clk_period = 8;
    localparam int n_instr    = 146; // 36 alu, 14 div, 60 mem, 6 exception and 30 mixed.

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    dec_in_t     in_data;
    logic        in_allow;
    logic        sram_en;
    logic [3:0]  sram_we;
    logic [31:0] sram_addr;
    logic [31:0] sram_wdata;
    logic [31:0] sram_rdata;
    logic        wb_valid;
    wb_t         wb_data;
    logic        wb_allow;

    logic [31:0] sram [0:255];
    logic [31:0] mem_model [0:255];
    wb_t         exp_q [$];
    wb_t         want_wb;
    wb_t         got_wb;
    string       cur_test;
    logic [31:0] pc_next;
    logic        bp_on;
    int          seed;
    int          errs_start;
    int          misc_errors;
    int          checks       = 0;
    int          mismatches   = 0;
    int          stall_cycles = 0;

    lx_slice u_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_allow   (in_allow),
        .sram_en    (sram_en),
        .sram_we    (sram_we),
        .sram_addr  (sram_addr),
        .sram_wdata (sram_wdata),
        .sram_rdata (sram_rdata),
        .wb_valid   (wb_valid),
        .wb_data    (wb_data),
        .wb_allow   (wb_allow)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) begin
        if (sram_en) begin
            sram_rdata <= sram[sram_addr[9:2]]; // data is back one cycle after the request.
            for (int i = 0; i < 4; i++) begin
                if (sram_we[i]) begin
                    sram[sram_addr[9:2]][8*i +: 8] <= sram_wdata[8*i +: 8];
                end
            end
        end
    end

    // outputs are settled at the falling edge, half a cycle before the handshake edge.
    always @(negedge clk) begin
        if (arst_n && wb_valid && wb_allow) begin
            if (exp_q.size() == 0) begin
                $display("%s: a writeback with pc %h arrived when none was expected",
                         cur_test, wb_data.pc);
                mismatches = mismatches + 1;
            end else begin
                want_wb = exp_q.pop_front();
                got_wb  = wb_data;
                if (!want_wb.we) begin
                    want_wb.data = '0; // the data of a writeback with we low carries no meaning.
                    got_wb.data  = '0;
                end
                check_value(cur_test, want_wb, got_wb);
            end
        end
        if (in_valid && !in_allow) begin
            stall_cycles = stall_cycles + 1;
        end
    end

    function automatic logic [31:0] fill_word(input int i);
        return {8'ha5, 8'(i), 8'(255 - i), 8'(i)};
    endfunction

    function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rk,
                                           input logic [4:0] rj, input logic [4:0] rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_2ri12(input logic [9:0] op, input logic [11:0] si12,
                                              input logic [4:0] rj, input logic [4:0] rd);
        return {op, si12, rj, rd};
    endfunction

    function automatic logic [31:0] signed_quotient(input logic [31:0] a, input logic [31:0] b);
        logic [31:0] mag_a;
        logic [31:0] mag_b;
        logic [31:0] q;
        mag_a = a[31] ? -a : a;
        mag_b = b[31] ? -b : b;
        q     = mag_a / mag_b;
        return (a[31] ^ b[31]) ? -q : q; // the quotient truncates toward zero.
    endfunction

    task automatic check_value(input string name, input wb_t expected, input wb_t actual);
        checks = checks + 1;
        if (actual !== expected) begin
            mismatches = mismatches + 1;
            $display("Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic model_instr(input logic [31:0] pc, input logic [31:0] word,
                               input logic [31:0] rj, input logic [31:0] rkd, output wb_t want);
        logic [9:0]  op10;
        logic [31:0] addr;
        logic [31:0] word_data;
        logic [7:0]  idx;
        int          size;
        int          off;
        logic        sgn;
        op10      = word[31:22];
        addr      = rj + {{20{word[21]}}, word[21:10]};
        idx       = addr[9:2];
        off       = int'(addr[1:0]);
        size      = 0;
        sgn       = (op10 == op_ld_b) || (op10 == op_ld_h);
        want      = '0;
        want.pc   = pc;
        want.dest = word[4:0];
        want.we   = 1'b1;
        want.exc  = exc_none;
        case (word[31:15])
            op_add_w:  want.data = rj + rkd;
            op_sub_w:  want.data = rj - rkd;
            op_and:    want.data = rj & rkd;
            op_or:     want.data = rj | rkd;
            op_xor:    want.data = rj ^ rkd;
            op_slt:    want.data = ($signed(rj) < $signed(rkd)) ? 32'd1 : 32'd0;
            op_sltu:   want.data = (rj < rkd) ? 32'd1 : 32'd0;
            op_div_w:  want.data = (rkd == 0) ? '1 : signed_quotient(rj, rkd);
            op_div_wu: want.data = (rkd == 0) ? '1 : rj / rkd;
            default: begin
                case (op10)
                    op_addi_w:                  want.data = addr;
                    op_ld_b, op_ld_bu, op_st_b: size = 1;
                    op_ld_h, op_ld_hu, op_st_h: size = 2;
                    op_ld_w, op_st_w:           size = 4;
                    default: begin
                        want.we  = 1'b0;
                        want.exc = exc_ine;
                    end
                endcase
            end
        endcase
        if (size != 0) begin
            if ((size == 2 && addr[0]) || (size == 4 && addr[1:0] != 2'b00)) begin
                want.we  = 1'b0;
                want.exc = exc_adem;
            end else if (op10 inside {op_st_b, op_st_h, op_st_w}) begin
                want.we = 1'b0;
                for (int b = 0; b < size; b++) begin
                    mem_model[idx][8*(off+b) +: 8] = rkd[8*b +: 8];
                end
            end else begin
                word_data = mem_model[idx] >> (8 * off);
                case (size)
                    1:       want.data = {{24{sgn & word_data[7]}}, word_data[7:0]};
                    2:       want.data = {{16{sgn & word_data[15]}}, word_data[15:0]};
                    default: want.data = word_data;
                endcase
            end
        end
    endtask

    // called at 1 ns after a rising edge and returns at the same point after acceptance.
    task automatic send_instr(input logic [31:0] word, input logic [31:0] rj,
                              input logic [31:0] rkd);
        wb_t  want;
        logic taken;
        model_instr(pc_next, word, rj, rkd, want);
        exp_q.push_back(want);
        in_data  = {pc_next, word, rj, rkd};
        in_valid = 1'b1;
        taken    = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_allow;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        pc_next  = pc_next + 32'd4;
    endtask

    task automatic wait_drain();
        do begin
            @(posedge clk);
        end while (exp_q.size() != 0);
        #1;
    endtask

    task automatic start_test(input string name);
        cur_test   = name;
        errs_start = mismatches + misc_errors;
    endtask

    task automatic report_test();
        wait_drain();
        $display("%s finished with %0d errors", cur_test, mismatches + misc_errors - errs_start);
    endtask

    task automatic test_alu();
        logic [16:0] ops [0:6];
        logic [31:0] a;
        logic [31:0] b;
        ops = '{op_add_w, op_sub_w, op_and, op_or, op_xor, op_slt, op_sltu};
        start_test("test_alu");
        for (int k = 0; k < 7; k++) begin
            for (int i = 0; i < 4; i++) begin
                a = $random(seed);
                b = $random(seed);
                if (i == 3) begin
                    b = a; // equal operands for the compare edge.
                end
                send_instr(enc_3r(ops[k], 5'd2, 5'd1, 5'(k + 4)), a, b);
            end
        end
        for (int i = 0; i < 8; i++) begin
            a     = $random(seed);
            b     = $random(seed);
            b[11] = i[0]; // every second immediate is negative.
            send_instr(enc_2ri12(op_addi_w, b[11:0], 5'd1, 5'(i + 1)), a, 32'd0);
        end
        report_test();
    endtask

    task automatic test_div();
        logic [31:0] a;
        logic [31:0] b;
        start_test("test_div");
        for (int i = 0; i < 8; i++) begin
            a = $random(seed);
            b = $random(seed);
            b = b >> ((i % 4) * 7); // narrower divisors give larger quotients.
            send_instr(enc_3r((i < 4) ? op_div_w : op_div_wu, 5'd2, 5'd1, 5'(i + 1)), a, b);
        end
        send_instr(enc_3r(op_div_w, 5'd2, 5'd1, 5'd9), 32'hffff_fff9, 32'd2);
        send_instr(enc_3r(op_div_w, 5'd2, 5'd1, 5'd10), 32'd7, 32'hffff_fffe);
        send_instr(enc_3r(op_div_w, 5'd2, 5'd1, 5'd11), 32'hffff_fff9, 32'hffff_fffe);
        send_instr(enc_3r(op_div_wu, 5'd2, 5'd1, 5'd12), 32'h8000_0000, 32'd3);
        send_instr(enc_3r(op_div_w, 5'd2, 5'd1, 5'd13), 32'd5, 32'd0);
        send_instr(enc_3r(op_div_wu, 5'd2, 5'd1, 5'd14), 32'hffff_fff0, 32'd0);
        report_test();
    endtask

    task automatic test_mem();
        logic [31:0] base;
        logic [31:0] val;
        base = 32'h110; // offsets of -16 to -1 reach the four words at 0x100.
        start_test("test_mem");
        for (int w = 0; w < 4; w++) begin
            val = $random(seed);
            send_instr(enc_2ri12(op_st_w, 12'(4 * w - 16), 5'd1, 5'd3), base, val);
        end
        val = $random(seed);
        send_instr(enc_2ri12(op_st_b, 12'(1 - 16), 5'd1, 5'd3), base, val);
        send_instr(enc_2ri12(op_st_b, 12'(11 - 16), 5'd1, 5'd3), base, ~val);
        val = $random(seed);
        send_instr(enc_2ri12(op_st_h, 12'(6 - 16), 5'd1, 5'd3), base, val);
        send_instr(enc_2ri12(op_st_h, 12'(12 - 16), 5'd1, 5'd3), base, ~val);
        for (int off = 0; off < 16; off++) begin
            send_instr(enc_2ri12(op_ld_b, 12'(off - 16), 5'd1, 5'(off + 1)), base, 32'd0);
            send_instr(enc_2ri12(op_ld_bu, 12'(off - 16), 5'd1, 5'(off + 1)), base, 32'd0);
            if (off % 2 == 0) begin
                send_instr(enc_2ri12(op_ld_h, 12'(off - 16), 5'd1, 5'(off + 1)), base, 32'd0);
                send_instr(enc_2ri12(op_ld_hu, 12'(off - 16), 5'd1, 5'(off + 1)), base, 32'd0);
            end
            if (off % 4 == 0) begin
                send_instr(enc_2ri12(op_ld_w, 12'(off - 16), 5'd1, 5'(off + 1)), base, 32'd0);
            end
        end
        report_test();
    endtask

    task automatic test_exceptions();
        start_test("test_exceptions");
        send_instr(enc_2ri12(op_ld_h, 12'd1, 5'd1, 5'd5), 32'h200, 32'd0);
        send_instr(enc_2ri12(op_ld_w, 12'd2, 5'd1, 5'd6), 32'h200, 32'd0);
        send_instr(enc_2ri12(op_st_w, 12'd2, 5'd1, 5'd7), 32'h200, 32'hdead_beef);
        send_instr(enc_2ri12(op_ld_w, 12'd0, 5'd1, 5'd8), 32'h200, 32'd0);
        send_instr(enc_2ri12(op_ld_w, 12'd4, 5'd1, 5'd9), 32'h200, 32'd0);
        send_instr(32'hffff_ffff, 32'd1, 32'd2); // no opcode in either format.
        report_test();
    endtask

    task automatic test_backpressure();
        logic [31:0] words [0:29];
        logic [31:0] rjs [0:29];
        logic [31:0] rkds [0:29];
        logic [31:0] a;
        logic [31:0] b;
        int          sel;
        int          stall_before;
        start_test("test_backpressure");
        for (int i = 0; i < 30; i++) begin
            sel     = int'($unsigned($random(seed)) % 8);
            a       = $random(seed);
            b       = $random(seed);
            rjs[i]  = a;
            rkds[i] = b;
            case (sel)
                0: words[i] = enc_3r(op_add_w, 5'd2, 5'd1, 5'(i));
                1: words[i] = enc_3r(op_sub_w, 5'd2, 5'd1, 5'(i));
                2: words[i] = enc_3r(op_xor, 5'd2, 5'd1, 5'(i));
                3: words[i] = enc_3r(op_div_w, 5'd2, 5'd1, 5'(i));
                4: words[i] = enc_3r(op_div_wu, 5'd2, 5'd1, 5'(i));
                5: words[i] = enc_2ri12(op_addi_w, a[11:0], 5'd1, 5'(i));
                6: begin
                    words[i] = enc_2ri12(op_st_w, 12'd0, 5'd1, 5'(i));
                    rjs[i]   = 32'h300 | {26'd0, a[5:2], 2'b00};
                end
                default: begin
                    words[i] = enc_2ri12(op_ld_b, 12'd0, 5'd1, 5'(i));
                    rjs[i]   = 32'h300 | {26'd0, a[5:0]};
                end
            endcase
        end
        stall_before = stall_cycles;
        bp_on        = 1'b1;
        fork
            begin
                for (int i = 0; i < 30; i++) begin
                    send_instr(words[i], rjs[i], rkds[i]);
                end
                wait_drain();
                bp_on = 1'b0;
            end
            while (bp_on) begin
                @(posedge clk);
                #1;
                wb_allow = ($random(seed) & 1) != 0;
            end
        join
        wb_allow = 1'b1;
        if (stall_cycles == stall_before) begin
            $display("test_backpressure: in_allow never fell while the pipeline was full");
            misc_errors = misc_errors + 1;
        end
        report_test();
    endtask

    initial begin
        #(n_instr * 40 * clk_period);
        $display("timeout: the pipeline stopped after %0d cycles", n_instr * 40);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        in_valid    = 1'b0;
        in_data     = '0;
        wb_allow    = 1'b1;
        bp_on       = 1'b0;
        seed        = 52;
        pc_next     = 32'h1c00_0000;
        misc_errors = 0;
        errs_start  = 0;
        cur_test    = "reset";
        sram_rdata <= '0;
        for (int i = 0; i < 256; i++) begin
            sram[i]     <= fill_word(i);
            mem_model[i] = fill_word(i);
        end
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        test_alu();
        test_div();
        test_mem();
        test_exceptions();
        test_backpressure();
        $display("%0d writebacks checked, %0d errors", checks, mismatches + misc_errors);
        if (mismatches + misc_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
